// ==== all.f ====
cache_pkg.sv
tag_way.sv
tag_fill_control.sv
hit_resolve.sv
tag_lookup_top.sv
tag_lookup_assertions.sv
tag_lookup_checker.sv
tb_tag_lookup.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_tag_lookup \
		-f all.f -o sim_tag_lookup

run: compile
	./obj_dir/sim_tag_lookup 2>&1 | tee sim.log
	@if grep -q "TB FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TB PASSED" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== tb_tag_lookup.sv ====
`timescale 1ns/10ps

module tb_tag_lookup;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int N_ROWS       = 20 + 40;

    logic                          clk, rst, op_valid;
    cache_pkg::tag_op_e            op, resp_op;
    logic [cache_pkg::INDEX_W-1:0] index;
    logic [cache_pkg::TAG_W-1:0]   tag, resp_evict_tag;
    logic                          resp_valid, resp_hit, resp_evict;
    logic [cache_pkg::WAY_W-1:0]   resp_way, tbl_way;
    logic                          tbl_chk, tbl_hit;
    int                            resp_count, error_count;
    int                            n_built;

    // Stimulus table, directed rows also carry the expected hit and way
    cache_pkg::tag_op_e            row_op [N_ROWS];
    logic [cache_pkg::INDEX_W-1:0] row_index [N_ROWS];
    logic [cache_pkg::TAG_W-1:0]   row_tag [N_ROWS];
    logic                          row_chk [N_ROWS];
    logic                          row_hit [N_ROWS];
    logic [cache_pkg::WAY_W-1:0]   row_way [N_ROWS];

    tag_lookup_top u_dut (.*);
    tag_lookup_checker u_chk (.*);

    task automatic add_row(input cache_pkg::tag_op_e o, input int idx, input int t,
                           input int chk, input int h, input int w);
        row_op[n_built]    = o;
        row_index[n_built] = cache_pkg::INDEX_W'(idx);
        row_tag[n_built]   = cache_pkg::TAG_W'(t);
        row_chk[n_built]   = (chk != 0);
        row_hit[n_built]   = (h != 0);
        row_way[n_built]   = cache_pkg::WAY_W'(w);
        n_built++;
    endtask

    task automatic build_table();
        n_built = 0;
        // Empty cache misses everywhere
        for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
            add_row(cache_pkg::OP_LOOKUP, s, 'h11, 1, 0, 0);
        end
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            add_row(cache_pkg::OP_FILL, 1, 'ha0 + w, 1, 0, w);
        end
        add_row(cache_pkg::OP_LOOKUP, 1, 'ha2, 1, 1, 2);
        add_row(cache_pkg::OP_LOOKUP, 1, 'ha0, 1, 1, 0);
        // Full set, evictions rotate from way 0
        add_row(cache_pkg::OP_FILL, 1, 'hb0, 1, 0, 0);
        add_row(cache_pkg::OP_FILL, 1, 'hb1, 1, 0, 1);
        add_row(cache_pkg::OP_FILL, 1, 'hb2, 1, 0, 2);
        add_row(cache_pkg::OP_FILL, 1, 'ha3, 1, 1, 3);
        add_row(cache_pkg::OP_LOOKUP, 1, 'hb1, 1, 1, 1);
        // Freed way is reused ahead of the pointer
        add_row(cache_pkg::OP_INVAL, 1, 'hb1, 1, 1, 1);
        add_row(cache_pkg::OP_LOOKUP, 1, 'hb1, 1, 0, 0);
        add_row(cache_pkg::OP_FILL, 1, 'hc0, 1, 0, 1);
        add_row(cache_pkg::OP_LOOKUP, 1, 'hc0, 1, 1, 1);
        // Pointer untouched by the fill hit, so way 3 goes next
        add_row(cache_pkg::OP_FILL, 1, 'hd0, 1, 0, 3);
        // Small tag pool keeps hits and evictions frequent
        while (n_built < N_ROWS) begin
            add_row(cache_pkg::tag_op_e'(2'($urandom_range(2, 0))),
                    int'($urandom_range(3, 0)), int'($urandom_range(15, 0)), 0, 0, 0);
        end
    endtask

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        void'($urandom(32'hb5afb200));
        rst      = 1'b1;
        op_valid = 1'b0;
        op       = cache_pkg::OP_LOOKUP;
        index    = '0;
        tag      = '0;
        tbl_chk  = 1'b0;
        tbl_hit  = 1'b0;
        tbl_way  = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < N_ROWS; r++) begin
            op_valid = 1'b1;
            op       = row_op[r];
            index    = row_index[r];
            tag      = row_tag[r];
            tbl_chk  = row_chk[r];
            tbl_hit  = row_hit[r];
            tbl_way  = row_way[r];
            @(negedge clk);
        end
        op_valid = 1'b0;
        tbl_chk  = 1'b0;
        wait (resp_count == N_ROWS);
        // Idle cycle after the last response is checked before the counts are read
        @(negedge clk);
        @(posedge clk);
        $display("Operations %0d, responses checked %0d, errors %0d",
                 N_ROWS, resp_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Reset plus one cycle per row, with margin for the last response
    initial begin
        #((RESET_CYCLES + N_ROWS + 20) * CLK_PERIOD);
        $display("Watchdog expired before all %0d responses were checked", N_ROWS);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== tag_lookup_checker.sv ====
`timescale 1ns/10ps

module tag_lookup_checker (
    input  logic                          clk, rst, op_valid,
    input  cache_pkg::tag_op_e            op, resp_op,
    input  logic [cache_pkg::INDEX_W-1:0] index,
    input  logic [cache_pkg::TAG_W-1:0]   tag, resp_evict_tag,
    input  logic                          resp_valid, resp_hit, resp_evict,
    input  logic [cache_pkg::WAY_W-1:0]   resp_way, tbl_way,
    input  logic                          tbl_chk, tbl_hit,
    output int                            resp_count, error_count
);

    // Reference copy of the tag store
    logic [cache_pkg::TAG_W-1:0]   m_tag [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
    logic                          m_valid [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
    logic [cache_pkg::WAY_W-1:0]   m_ptr [cache_pkg::NUM_SETS];

    // Prediction for the response seen at the next falling edge
    bit                            started, op_ok;
    logic                          e_valid, e_hit, e_evict, e_way_def, e_tbl, e_tbl_hit;
    logic [cache_pkg::WAY_W-1:0]   e_way, e_tbl_way;
    logic [cache_pkg::TAG_W-1:0]   e_etag, e_tag;
    logic [cache_pkg::INDEX_W-1:0] e_set;
    cache_pkg::tag_op_e            e_op;

    task automatic compare_field(input string name, input logic [31:0] expv,
                                 input logic [31:0] actv);
        if (actv !== expv) begin
            $display("Error: %0d ns %s expected %0h actual %0h", $time, name, expv, actv);
            error_count++;
            op_ok = 1'b0;
        end
    endtask

    task automatic predict();
        int h;
        int w;
        h = -1;
        w = -1;
        for (int i = 0; i < cache_pkg::NUM_WAYS; i++) begin
            if (m_valid[index][i] && m_tag[index][i] == tag) begin
                h = i;
            end
        end
        e_op      = op;
        e_set     = index;
        e_tag     = tag;
        e_hit     = (h >= 0);
        e_way_def = (h >= 0);
        e_way     = cache_pkg::WAY_W'(h);
        e_evict   = 1'b0;
        e_etag    = '0;
        if (op == cache_pkg::OP_FILL && h < 0) begin
            // Lowest free way first, round-robin pointer once the set is full
            for (int i = cache_pkg::NUM_WAYS - 1; i >= 0; i--) begin
                if (!m_valid[index][i]) begin
                    w = i;
                end
            end
            if (w < 0) begin
                w = int'(m_ptr[index]);
                e_evict = 1'b1;
                e_etag = m_tag[index][w];
                m_ptr[index] = m_ptr[index] + cache_pkg::WAY_W'(1);
            end
            m_tag[index][w]   = tag;
            m_valid[index][w] = 1'b1;
            e_way     = cache_pkg::WAY_W'(w);
            e_way_def = 1'b1;
        end else if (op == cache_pkg::OP_INVAL && h >= 0) begin
            m_valid[index][h] = 1'b0;
        end
    endtask

    // Inputs are stable at the rising edge
    always @(posedge clk) begin
        started   = 1'b1;
        e_valid   = op_valid && !rst;
        e_tbl     = tbl_chk;
        e_tbl_hit = tbl_hit;
        e_tbl_way = tbl_way;
        if (rst) begin
            for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
                m_ptr[s] = '0;
                for (int i = 0; i < cache_pkg::NUM_WAYS; i++) begin
                    m_valid[s][i] = 1'b0;
                end
            end
        end else if (op_valid) begin
            predict();
        end
    end

    // Registered response settles well before the falling edge
    always @(negedge clk) begin
        if (started) begin
            op_ok = 1'b1;
            compare_field("resp_valid", 32'(e_valid), 32'(resp_valid));
            if (e_valid && resp_valid) begin
                compare_field("resp_op", 32'(e_op), 32'(resp_op));
                compare_field("resp_hit", 32'(e_hit), 32'(resp_hit));
                compare_field("resp_evict", 32'(e_evict), 32'(resp_evict));
                if (e_way_def) begin
                    compare_field("resp_way", 32'(e_way), 32'(resp_way));
                end
                if (e_evict) begin
                    compare_field("resp_evict_tag", 32'(e_etag), 32'(resp_evict_tag));
                end
                if (e_tbl) begin
                    compare_field("resp_hit (table)", 32'(e_tbl_hit), 32'(resp_hit));
                    if (e_way_def) begin
                        compare_field("resp_way (table)", 32'(e_tbl_way), 32'(resp_way));
                    end
                end
                resp_count++;
                $display("%0d ns %s set %0d tag %02h: hit %0b way %0d evict %0b %s", $time,
                         e_op.name(), e_set, e_tag, resp_hit, resp_way, resp_evict,
                         op_ok ? "ok" : "MISMATCH");
            end
        end
    end

endmodule

// ==== tag_lookup_assertions.sv ====
`timescale 1ns/10ps

module tag_lookup_assertions (
    input logic                           clk, rst, op_valid, resp_valid,
    input logic [cache_pkg::NUM_WAYS-1:0] hit, fill_we
);

    // A tag lives in at most one way of a set
    hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit))
        else $error("More than one way hit at once");

    fill_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(fill_we))
        else $error("Fill wrote more than one way");

    resp_follows_op: assert property (@(posedge clk) disable iff (rst) op_valid |=> resp_valid)
        else $error("Operation produced no response in the next cycle");

    no_stray_resp: assert property (@(posedge clk) disable iff (rst) !op_valid |=> !resp_valid)
        else $error("Response without an operation");

endmodule

bind tag_lookup_top tag_lookup_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .op_valid   (op_valid),
    .resp_valid (resp_valid),
    .hit        (hit),
    .fill_we    (fill_we)
);

// ==== tag_lookup_top.sv ====
`timescale 1ns/10ps

module tag_lookup_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          op_valid,
    input  cache_pkg::tag_op_e            op,
    input  logic [cache_pkg::INDEX_W-1:0] index,
    input  logic [cache_pkg::TAG_W-1:0]   tag,
    output logic                          resp_valid,
    output cache_pkg::tag_op_e            resp_op,
    output logic                          resp_hit,
    output logic [cache_pkg::WAY_W-1:0]   resp_way,
    output logic                          resp_evict,
    output logic [cache_pkg::TAG_W-1:0]   resp_evict_tag
);

    logic [cache_pkg::NUM_WAYS-1:0]                 hit;
    logic [cache_pkg::NUM_WAYS-1:0]                 set_valid;
    logic [cache_pkg::NUM_WAYS*cache_pkg::TAG_W-1:0] stored_tag;
    logic                                           lookup_en;
    logic [cache_pkg::NUM_WAYS-1:0]                 fill_we;
    logic                                           inval_en;
    logic                                           fill_en;
    logic [cache_pkg::NUM_WAYS-1:0]                 victim;
    logic                                           evict;

    tag_fill_control u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .op_valid  (op_valid),
        .op        (op),
        .index     (index),
        .hit       (hit),
        .set_valid (set_valid),
        .lookup_en (lookup_en),
        .fill_we   (fill_we),
        .inval_en  (inval_en),
        .fill_en   (fill_en),
        .victim    (victim),
        .evict     (evict)
    );

    // One tag_way per way, tags packed with way 0 in the low byte
    genvar i;
    generate
        for (i = 0; i < cache_pkg::NUM_WAYS; i = i + 1) begin : way_gen
            tag_way u_way (
                .clk        (clk),
                .rst        (rst),
                .index      (index),
                .tag        (tag),
                .fill_we    (fill_we[i]),
                .inval_en   (inval_en),
                .hit        (hit[i]),
                .set_valid  (set_valid[i]),
                .stored_tag (stored_tag[i*cache_pkg::TAG_W +: cache_pkg::TAG_W])
            );
        end
    endgenerate

    hit_resolve u_resolve (
        .clk            (clk),
        .rst            (rst),
        .lookup_en      (lookup_en),
        .fill_en        (fill_en),
        .inval_en       (inval_en),
        .evict          (evict),
        .victim         (victim),
        .hit            (hit),
        .stored_tag     (stored_tag),
        .resp_valid     (resp_valid),
        .resp_op        (resp_op),
        .resp_hit       (resp_hit),
        .resp_way       (resp_way),
        .resp_evict     (resp_evict),
        .resp_evict_tag (resp_evict_tag)
    );

endmodule

// ==== hit_resolve.sv ====
`timescale 1ns/10ps

module hit_resolve (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       lookup_en,
    input  logic                                       fill_en,
    input  logic                                       inval_en,
    input  logic                                       evict,
    input  logic [cache_pkg::NUM_WAYS-1:0]             victim,
    input  logic [cache_pkg::NUM_WAYS-1:0]             hit,
    input  logic [cache_pkg::NUM_WAYS*cache_pkg::TAG_W-1:0] stored_tag,
    output logic                                       resp_valid,
    output cache_pkg::tag_op_e                         resp_op,
    output logic                                       resp_hit,
    output logic [cache_pkg::WAY_W-1:0]                resp_way,
    output logic                                       resp_evict,
    output logic [cache_pkg::TAG_W-1:0]                resp_evict_tag
);

    logic [cache_pkg::NUM_WAYS-1:0] sel_vec;
    logic [cache_pkg::WAY_W-1:0]    sel_way;
    logic [cache_pkg::TAG_W-1:0]    old_tag;
    cache_pkg::tag_op_e             next_op;

    function automatic logic [cache_pkg::WAY_W-1:0] onehot_to_way(
        input logic [cache_pkg::NUM_WAYS-1:0] vec
    );
        logic [cache_pkg::WAY_W-1:0] way;
        way = '0;
        for (int i = 0; i < cache_pkg::NUM_WAYS; i++) begin
            if (vec[i]) begin
                way = cache_pkg::WAY_W'(i);
            end
        end
        return way;
    endfunction

    // Fills report the chosen way, everything else the hitting way
    assign sel_vec = fill_en ? victim : hit;
    assign sel_way = onehot_to_way(sel_vec);

    // Tag mux by way number
    assign old_tag = stored_tag[sel_way*cache_pkg::TAG_W +: cache_pkg::TAG_W];

    always_comb begin
        if (fill_en) begin
            next_op = cache_pkg::OP_FILL;
        end else if (inval_en) begin
            next_op = cache_pkg::OP_INVAL;
        end else begin
            next_op = cache_pkg::OP_LOOKUP;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= lookup_en | fill_en | inval_en;
        end
    end

    // Response payload, meaningful only while resp_valid is high
    always_ff @(posedge clk) begin
        resp_op        <= next_op;
        resp_hit       <= |hit;
        resp_way       <= sel_way;
        resp_evict     <= evict;
        resp_evict_tag <= evict ? old_tag : '0;
    end

endmodule

// ==== tag_fill_control.sv ====
`timescale 1ns/10ps

module tag_fill_control (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  op_valid,
    input  cache_pkg::tag_op_e                    op,
    input  logic [cache_pkg::INDEX_W-1:0]         index,
    input  logic [cache_pkg::NUM_WAYS-1:0]        hit,
    input  logic [cache_pkg::NUM_WAYS-1:0]        set_valid,
    output logic                                  lookup_en,
    output logic [cache_pkg::NUM_WAYS-1:0]        fill_we,
    output logic                                  inval_en,
    output logic                                  fill_en,
    output logic [cache_pkg::NUM_WAYS-1:0]        victim,
    output logic                                  evict
);

    // Round-robin replacement pointer, one per set
    logic [cache_pkg::WAY_W-1:0]    rr_ptr [cache_pkg::NUM_SETS];

    logic                           any_hit;
    logic                           set_full;
    logic [cache_pkg::NUM_WAYS-1:0] free_way;
    logic [cache_pkg::NUM_WAYS-1:0] ptr_way;
    logic                           fill_miss;

    assign any_hit  = |hit;
    assign set_full = &set_valid;

    // Opcode decode, the only place op is looked at
    always_comb begin
        lookup_en = 1'b0;
        fill_en   = 1'b0;
        inval_en  = 1'b0;
        if (op_valid) begin
            case (op)
                cache_pkg::OP_LOOKUP: lookup_en = 1'b1;
                cache_pkg::OP_FILL:   fill_en   = 1'b1;
                cache_pkg::OP_INVAL:  inval_en  = 1'b1;
                default:              lookup_en = 1'b0;
            endcase
        end
    end

    // Lowest-index invalid way, zero when the set is full
    always_comb begin
        free_way = '0;
        for (int i = cache_pkg::NUM_WAYS - 1; i >= 0; i--) begin
            if (!set_valid[i]) begin
                free_way    = '0;
                free_way[i] = 1'b1;
            end
        end
    end

    assign ptr_way = {{(cache_pkg::NUM_WAYS-1){1'b0}}, 1'b1} << rr_ptr[index];

    // A fill that hits points the victim at the matching way so the
    // resolver reports it like a lookup hit
    always_comb begin
        if (any_hit) begin
            victim = hit;
        end else if (!set_full) begin
            victim = free_way;
        end else begin
            victim = ptr_way;
        end
    end

    assign fill_miss = fill_en & ~any_hit;
    assign fill_we   = fill_miss ? victim : '0;
    assign evict     = fill_miss & set_full;

    // Pointer moves only when a valid entry is replaced
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
                rr_ptr[s] <= '0;
            end
        end else if (evict) begin
            rr_ptr[index] <= rr_ptr[index] + cache_pkg::WAY_W'(1);
        end
    end

endmodule

// ==== tag_way.sv ====
`timescale 1ns/10ps

module tag_way (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [cache_pkg::INDEX_W-1:0] index,
    input  logic [cache_pkg::TAG_W-1:0]   tag,
    input  logic                          fill_we,
    input  logic                          inval_en,
    output logic                          hit,
    output logic                          set_valid,
    output logic [cache_pkg::TAG_W-1:0]   stored_tag
);

    // Tag array and valid bits of this way, one entry per set
    logic [cache_pkg::TAG_W-1:0] tag_mem [cache_pkg::NUM_SETS];
    logic [cache_pkg::NUM_SETS-1:0] valid_q;

    logic tag_match;

    // Read side is combinational from index
    assign stored_tag = tag_mem[index];
    assign set_valid  = valid_q[index];

    // Comparator qualified by the valid bit
    assign tag_match = (stored_tag == tag);
    assign hit       = tag_match & set_valid;

    // Tag storage
    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[index] <= tag;
        end
    end

    // Valid bits, set on fill and cleared by a matching invalidate
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_we) begin
            valid_q[index] <= 1'b1;
        end else if (inval_en && hit) begin
            valid_q[index] <= 1'b0;
        end
    end

endmodule

// ==== cache_pkg.sv ====
package cache_pkg;

    // Cache geometry, four ways by four sets
    localparam int NUM_WAYS = 4;
    localparam int NUM_SETS = 4;

    // Index selects one of NUM_SETS sets
    localparam int INDEX_W = 2;

    // Tag kept per entry
    localparam int TAG_W = 8;

    // Encoded way number
    localparam int WAY_W = 2;

    // Operations accepted on the request strobe
    typedef enum logic [1:0] {
        OP_LOOKUP = 2'd0,
        OP_FILL   = 2'd1,
        OP_INVAL  = 2'd2
    } tag_op_e;

endpackage
